//--- sprite_dma_pkg.sv
`default_nettype none

package sprite_dma_pkg;

    localparam int DATA_W     = 16;
    localparam int ADDR_W     = 11;
    localparam int PAL_ADDR_W = 13;

    // Register offsets on the CPU address while reg_cs is set
    localparam logic [ADDR_W-1:0] REG_OBJ_PTR   = 11'd0;
    localparam logic [ADDR_W-1:0] REG_DIRECT    = 11'd1;
    localparam logic [ADDR_W-1:0] REG_COPY_MODE = 11'd2;
    localparam logic [ADDR_W-1:0] REG_START     = 11'd4;

    // The palette image sits in the upper half of the list buffer
    localparam logic [ADDR_W-1:0] PAL_SRC_BASE = 11'd1024;
    localparam int                PAL_WORDS    = 1024;

    typedef enum logic [2:0] {
        idle,
        copy_pal,
        clear_obj,
        init_obj,
        copy_obj
    } copy_state_t;

endpackage

`default_nettype wire

//--- list_ram.sv
`timescale 1ns/1ps
`default_nettype none

module list_ram #(
    parameter int DEPTH = 2048,
    parameter int WIDTH = 16,
    localparam int AW   = $clog2(DEPTH)
) (
    input  wire logic             clk,
    input  wire logic             we,
    input  wire logic [AW-1:0]    waddr,
    input  wire logic [AW-1:0]    raddr,
    input  wire logic [WIDTH-1:0] wdata,
    output logic      [WIDTH-1:0] rdata
);

    logic [WIDTH-1:0] mem [DEPTH];

    always_ff @(posedge clk) begin
        if (we) begin
            mem[waddr] <= wdata;
        end
        rdata <= mem[raddr]; // A read that collides with a write sees the old word
    end

endmodule

`default_nettype wire

//--- cpu_port.sv
`timescale 1ns/1ps
`default_nettype none

module cpu_port #(
    parameter int DATA_W = sprite_dma_pkg::DATA_W,
    parameter int ADDR_W = sprite_dma_pkg::ADDR_W
) (
    input  wire logic              clk,
    input  wire logic              reset,
    input  wire logic [ADDR_W-1:0] addr,
    input  wire logic [DATA_W-1:0] din,
    input  wire logic              wr,
    input  wire logic              reg_cs,
    input  wire logic              buf_cs,
    input  wire logic              busy,
    input  wire logic [ADDR_W-1:0] eng_buf_addr,
    output logic                   buf_we,
    output logic      [ADDR_W-1:0] buf_waddr,
    output logic      [ADDR_W-1:0] buf_raddr,
    output logic      [7:0]        reg_obj_ptr,
    output logic      [2:0]        pal_bank,
    output logic                   direct_obj,
    output logic                   direct_pal,
    output logic                   start
);

    logic reg_wr;
    logic direct_any;

    assign reg_wr     = reg_cs && wr;
    assign direct_any = direct_obj || direct_pal;

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            reg_obj_ptr <= '0;
            pal_bank    <= '0;
            direct_obj  <= 1'b0;
            direct_pal  <= 1'b0;
        end else if (reg_wr) begin
            case (addr)
                sprite_dma_pkg::REG_OBJ_PTR: begin
                    reg_obj_ptr <= din[7:0];
                end
                sprite_dma_pkg::REG_DIRECT: begin
                    direct_obj <= din[0];
                    direct_pal <= din[1];
                end
                sprite_dma_pkg::REG_COPY_MODE: begin
                    pal_bank <= din[10:8]; // Only the bank field of the mode word is kept
                end
                default: begin
                end
            endcase
        end
    end

    // A start while a copy runs is ignored
    assign start = reg_wr && (addr == sprite_dma_pkg::REG_START) && !busy;

    // In direct mode the CPU buffer cycle belongs to the object or palette RAM
    assign buf_we    = buf_cs && wr && !busy && !direct_any;
    assign buf_waddr = addr;

    // The engine owns the read port from the start cycle on so its first word is ready
    assign buf_raddr = (busy || start) ? eng_buf_addr : addr;

    // An accepted start raises busy on the following edge
    assert property (@(posedge clk) disable iff (reset) start |=> busy);

endmodule

`default_nettype wire

//--- copy_engine.sv
`timescale 1ns/1ps
`default_nettype none

module copy_engine #(
    parameter int DATA_W    = sprite_dma_pkg::DATA_W,
    parameter int ADDR_W    = sprite_dma_pkg::ADDR_W,
    parameter int PAL_IDX_W = sprite_dma_pkg::PAL_ADDR_W - 3
) (
    input  wire logic                 clk,
    input  wire logic                 reset,
    input  wire logic                 ce,
    input  wire logic                 start,
    input  wire logic [7:0]           reg_obj_ptr,
    input  wire logic [DATA_W-1:0]    buf_rdata,
    output logic                      busy,
    output logic      [ADDR_W-1:0]    eng_buf_addr,
    output logic      [ADDR_W-1:0]    eng_obj_addr,
    output logic      [PAL_IDX_W-1:0] eng_pal_addr,
    output logic      [DATA_W-1:0]    eng_data,
    output logic                      eng_obj_we,
    output logic                      eng_pal_we
);

    localparam logic [ADDR_W-1:0] PAL_LAST =
        ADDR_W'(sprite_dma_pkg::PAL_SRC_BASE + sprite_dma_pkg::PAL_WORDS - 1);

    sprite_dma_pkg::copy_state_t state;

    logic [ADDR_W-1:0] buf_addr_q;
    logic [ADDR_W-1:0] buf_addr_d;
    logic [ADDR_W:0]   next_entry; // Carries one extra bit to catch the run past the buffer end
    logic              list_end;
    logic [8:0]        obj_idx;
    logic [8:0]        next_idx;
    logic [3:0]        cols;
    logic [1:0]        word;
    logic [ADDR_W-1:0] pal_offset;
    logic [ADDR_W-1:0] slot_addr;

    assign busy       = state != sprite_dma_pkg::idle;
    assign word       = buf_addr_q[1:0]; // Entries stay four-word aligned
    assign cols       = 4'd1 << buf_rdata[12:11];
    assign next_idx   = obj_idx - 9'(cols); // Bit 8 flags a negative slot index
    assign pal_offset = buf_addr_q - sprite_dma_pkg::PAL_SRC_BASE;
    assign slot_addr  = ADDR_W'({(word == 2'd0) ? next_idx[7:0] : obj_idx[7:0], word});

    always_comb begin
        case (state)
            sprite_dma_pkg::idle: begin
                buf_addr_d = start ? sprite_dma_pkg::PAL_SRC_BASE : buf_addr_q;
            end
            sprite_dma_pkg::copy_pal: begin
                buf_addr_d = (buf_addr_q == PAL_LAST) ? '0 : buf_addr_q + 1'b1;
            end
            sprite_dma_pkg::init_obj: begin
                buf_addr_d = '0;
            end
            sprite_dma_pkg::copy_obj: begin
                if (word == 2'd3) begin
                    buf_addr_d = next_entry[ADDR_W-1:0];
                end else begin
                    buf_addr_d = buf_addr_q + 1'b1;
                end
            end
            default: begin
                buf_addr_d = buf_addr_q + 1'b1; // The clear phase uses the pointer as its counter
            end
        endcase
    end

    // The RAM sees the next address a cycle early, so buf_rdata always holds word buf_addr_q
    assign eng_buf_addr = (ce || !busy) ? buf_addr_d : buf_addr_q;

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            state      <= sprite_dma_pkg::idle;
            buf_addr_q <= '0;
            next_entry <= '0;
            list_end   <= 1'b0;
            obj_idx    <= '0;
            eng_obj_we <= 1'b0;
            eng_pal_we <= 1'b0;
        end else if (!busy) begin
            if (start) begin
                state      <= sprite_dma_pkg::copy_pal;
                buf_addr_q <= buf_addr_d;
            end
        end else if (ce) begin
            buf_addr_q <= buf_addr_d;
            eng_obj_we <= 1'b0;
            eng_pal_we <= 1'b0;
            case (state)
                sprite_dma_pkg::copy_pal: begin
                    eng_pal_we <= 1'b1;
                    if (buf_addr_q == PAL_LAST) begin
                        state <= sprite_dma_pkg::clear_obj;
                    end
                end
                sprite_dma_pkg::clear_obj: begin
                    eng_obj_we <= 1'b1;
                    if (&buf_addr_q) begin
                        state <= sprite_dma_pkg::init_obj;
                    end
                end
                sprite_dma_pkg::init_obj: begin
                    obj_idx  <= 9'h100 - 9'(reg_obj_ptr);
                    list_end <= 1'b0;
                    state    <= sprite_dma_pkg::copy_obj;
                end
                sprite_dma_pkg::copy_obj: begin
                    if (word == 2'd0 && (list_end || next_idx[8])) begin
                        state <= sprite_dma_pkg::idle;
                    end else begin
                        eng_obj_we <= 1'b1;
                        if (word == 2'd0) begin
                            obj_idx    <= next_idx;
                            next_entry <= {1'b0, buf_addr_q} + (ADDR_W + 1)'({cols, 2'b00});
                        end
                        if (word == 2'd3) begin
                            list_end <= next_entry[ADDR_W];
                        end
                    end
                end
                default: begin
                end
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (busy && ce) begin
            eng_data     <= (state == sprite_dma_pkg::clear_obj) ? '0 : buf_rdata;
            eng_pal_addr <= pal_offset[PAL_IDX_W-1:0];
            eng_obj_addr <= (state == sprite_dma_pkg::clear_obj) ? buf_addr_q : slot_addr;
        end
    end

    assert property (@(posedge clk) disable iff (reset) !(eng_obj_we && eng_pal_we));

    // Every write strobe falls before or with busy
    assert property (@(posedge clk) disable iff (reset) !busy |-> !(eng_obj_we || eng_pal_we));

endmodule

`default_nettype wire

//--- memory_router.sv
`timescale 1ns/1ps
`default_nettype none

module memory_router #(
    parameter int DATA_W      = sprite_dma_pkg::DATA_W,
    parameter int ADDR_W      = sprite_dma_pkg::ADDR_W,
    parameter int PAL_ADDR_W  = sprite_dma_pkg::PAL_ADDR_W,
    parameter int CNT_W       = 10,
    localparam int PAL_IDX_W  = PAL_ADDR_W - 3
) (
    input  wire logic [ADDR_W-1:0]     addr,
    input  wire logic [DATA_W-1:0]     din,
    input  wire logic                  wr,
    input  wire logic                  buf_cs,
    input  wire logic                  direct_obj,
    input  wire logic                  direct_pal,
    input  wire logic [2:0]            pal_bank,
    input  wire logic                  busy,
    input  wire logic [CNT_W-1:0]      count,
    input  wire logic [DATA_W-1:0]     buf_rdata,
    input  wire logic [DATA_W-1:0]     obj_din,
    input  wire logic [DATA_W-1:0]     pal_din,
    input  wire logic [ADDR_W-1:0]     eng_obj_addr,
    input  wire logic [PAL_IDX_W-1:0]  eng_pal_addr,
    input  wire logic [DATA_W-1:0]     eng_data,
    input  wire logic                  eng_obj_we,
    input  wire logic                  eng_pal_we,
    output logic      [DATA_W-1:0]     dout,
    output logic      [ADDR_W-1:0]     obj_addr,
    output logic      [DATA_W-1:0]     obj_dout,
    output logic                       obj_we,
    output logic      [PAL_ADDR_W-1:0] pal_addr,
    output logic      [DATA_W-1:0]     pal_dout,
    output logic                       pal_we,
    output logic                       pal_cs
);

    logic cpu_wr;

    assign cpu_wr = buf_cs && wr;

    // Object RAM goes to the CPU first, then the engine, then the video scan
    assign obj_addr = direct_obj ? addr : (busy ? eng_obj_addr : ADDR_W'(count));
    assign obj_dout = direct_obj ? din : eng_data;
    assign obj_we   = direct_obj ? cpu_wr : (busy && eng_obj_we);

    assign pal_addr = {pal_bank, direct_pal ? addr[PAL_IDX_W-1:0] :
                                 (busy ? eng_pal_addr : PAL_IDX_W'(0))};
    assign pal_dout = direct_pal ? din : eng_data;
    assign pal_we   = direct_pal ? cpu_wr : (busy && eng_pal_we);
    assign pal_cs   = direct_pal && buf_cs;

    assign dout = direct_obj ? obj_din : (direct_pal ? pal_din : buf_rdata);

endmodule

`default_nettype wire

//--- sprite_list_dma.sv
`timescale 1ns/1ps
`default_nettype none

module sprite_list_dma #(
    parameter int DATA_W     = sprite_dma_pkg::DATA_W,
    parameter int ADDR_W     = sprite_dma_pkg::ADDR_W,
    parameter int PAL_ADDR_W = sprite_dma_pkg::PAL_ADDR_W,
    parameter int CNT_W      = 10
) (
    input  wire logic                  clk,
    input  wire logic                  ce,
    input  wire logic                  reset,
    input  wire logic [DATA_W-1:0]     din,
    output logic      [DATA_W-1:0]     dout,
    input  wire logic [ADDR_W-1:0]     addr,
    input  wire logic                  reg_cs,
    input  wire logic                  buf_cs,
    input  wire logic                  wr,
    output logic                       busy,
    input  wire logic [CNT_W-1:0]      count,
    output logic      [DATA_W-1:0]     obj_dout,
    input  wire logic [DATA_W-1:0]     obj_din,
    output logic      [ADDR_W-1:0]     obj_addr,
    output logic                       obj_we,
    output logic      [PAL_ADDR_W-1:0] pal_addr,
    output logic      [DATA_W-1:0]     pal_dout,
    input  wire logic [DATA_W-1:0]     pal_din,
    output logic                       pal_we,
    output logic                       pal_cs
);

    localparam int PAL_IDX_W = PAL_ADDR_W - 3;

    logic                 buf_we;
    logic [ADDR_W-1:0]    buf_waddr;
    logic [ADDR_W-1:0]    buf_raddr;
    logic [DATA_W-1:0]    buf_rdata;
    logic [7:0]           reg_obj_ptr;
    logic [2:0]           pal_bank;
    logic                 direct_obj;
    logic                 direct_pal;
    logic                 start;
    logic [ADDR_W-1:0]    eng_buf_addr;
    logic [ADDR_W-1:0]    eng_obj_addr;
    logic [PAL_IDX_W-1:0] eng_pal_addr;
    logic [DATA_W-1:0]    eng_data;
    logic                 eng_obj_we;
    logic                 eng_pal_we;

    list_ram #(
        .DEPTH (1 << ADDR_W),
        .WIDTH (DATA_W)
    ) u_list_ram (
        .clk   (clk),
        .we    (buf_we),
        .waddr (buf_waddr),
        .raddr (buf_raddr),
        .wdata (din),
        .rdata (buf_rdata)
    );

    cpu_port #(
        .DATA_W (DATA_W),
        .ADDR_W (ADDR_W)
    ) u_cpu_port (
        .clk          (clk),
        .reset        (reset),
        .addr         (addr),
        .din          (din),
        .wr           (wr),
        .reg_cs       (reg_cs),
        .buf_cs       (buf_cs),
        .busy         (busy),
        .eng_buf_addr (eng_buf_addr),
        .buf_we       (buf_we),
        .buf_waddr    (buf_waddr),
        .buf_raddr    (buf_raddr),
        .reg_obj_ptr  (reg_obj_ptr),
        .pal_bank     (pal_bank),
        .direct_obj   (direct_obj),
        .direct_pal   (direct_pal),
        .start        (start)
    );

    copy_engine #(
        .DATA_W    (DATA_W),
        .ADDR_W    (ADDR_W),
        .PAL_IDX_W (PAL_IDX_W)
    ) u_copy_engine (
        .clk          (clk),
        .reset        (reset),
        .ce           (ce),
        .start        (start),
        .reg_obj_ptr  (reg_obj_ptr),
        .buf_rdata    (buf_rdata),
        .busy         (busy),
        .eng_buf_addr (eng_buf_addr),
        .eng_obj_addr (eng_obj_addr),
        .eng_pal_addr (eng_pal_addr),
        .eng_data     (eng_data),
        .eng_obj_we   (eng_obj_we),
        .eng_pal_we   (eng_pal_we)
    );

    memory_router #(
        .DATA_W     (DATA_W),
        .ADDR_W     (ADDR_W),
        .PAL_ADDR_W (PAL_ADDR_W),
        .CNT_W      (CNT_W)
    ) u_memory_router (
        .addr         (addr),
        .din          (din),
        .wr           (wr),
        .buf_cs       (buf_cs),
        .direct_obj   (direct_obj),
        .direct_pal   (direct_pal),
        .pal_bank     (pal_bank),
        .busy         (busy),
        .count        (count),
        .buf_rdata    (buf_rdata),
        .obj_din      (obj_din),
        .pal_din      (pal_din),
        .eng_obj_addr (eng_obj_addr),
        .eng_pal_addr (eng_pal_addr),
        .eng_data     (eng_data),
        .eng_obj_we   (eng_obj_we),
        .eng_pal_we   (eng_pal_we),
        .dout         (dout),
        .obj_addr     (obj_addr),
        .obj_dout     (obj_dout),
        .obj_we       (obj_we),
        .pal_addr     (pal_addr),
        .pal_dout     (pal_dout),
        .pal_we       (pal_we),
        .pal_cs       (pal_cs)
    );

endmodule

`default_nettype wire

//--- sprite_list_dma_tb.sv
`timescale 1ns/1ps
`default_nettype none

module sprite_list_dma_tb;

    localparam int          DW         = sprite_dma_pkg::DATA_W;
    localparam int          AW         = sprite_dma_pkg::ADDR_W;
    localparam int          OBJ_WORDS  = 1 << AW;
    localparam int          PAL_TOTAL  = 1 << sprite_dma_pkg::PAL_ADDR_W;
    localparam int          PAL_WORDS  = sprite_dma_pkg::PAL_WORDS;
    localparam int          PAL_BASE   = int'(sprite_dma_pkg::PAL_SRC_BASE);
    localparam int          WAIT_LIMIT = 20000;
    localparam logic [31:0] SEED       = 32'he784_30fc;

    logic          clk;
    logic          ce;
    logic          reset;
    logic [DW-1:0] din;
    logic [DW-1:0] dout;
    logic [AW-1:0] addr;
    logic          reg_cs;
    logic          buf_cs;
    logic          wr;
    logic          busy;
    logic [9:0]    count;
    logic [DW-1:0] obj_dout;
    logic [DW-1:0] obj_din;
    logic [AW-1:0] obj_addr;
    logic          obj_we;
    logic [12:0]   pal_addr;
    logic [DW-1:0] pal_dout;
    logic [DW-1:0] pal_din;
    logic          pal_we;
    logic          pal_cs;

    logic [DW-1:0] obj_mem   [OBJ_WORDS];
    logic [DW-1:0] pal_mem   [PAL_TOTAL];
    logic [DW-1:0] exp_obj   [OBJ_WORDS];
    logic [DW-1:0] exp_pal   [PAL_TOTAL];
    logic [DW-1:0] buf_model [OBJ_WORDS];
    logic [AW-1:0] touched_q [$];
    logic [31:0]   rng;
    logic [31:0]   ce_rng;
    logic [7:0]    obj_ptr_q;
    logic [2:0]    bank_q;
    int            errors;
    int            test_mark;
    int            tests_failed;

    sprite_list_dma #(.CNT_W(10)) uut (.*);

    always #2 clk = ~clk;

    always @(posedge clk) begin
        ce_rng = xorshift(ce_rng);
        ce     <= ce_rng[1:0] != 2'b00; // About three enabled cycles in four
    end

    // External object and palette RAMs
    assign obj_din = obj_mem[obj_addr];
    assign pal_din = pal_mem[pal_addr];

    always @(posedge clk) begin
        if (obj_we) begin
            obj_mem[obj_addr] <= obj_dout;
        end
        if (pal_we) begin
            pal_mem[pal_addr] <= pal_dout;
        end
    end

    function automatic logic [31:0] xorshift(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    function automatic logic [31:0] next_rand();
        rng = xorshift(rng);
        return rng;
    endfunction

    task automatic check(input string name, input logic [31:0] expected,
                         input logic [31:0] actual);
        if (actual !== expected) begin
            $display("[FAIL] %s: expected %h, actual %h", name, expected, actual);
            errors++;
        end
    endtask

    task automatic finish_test(input string name);
        if (errors == test_mark) begin
            $display("test %s: ok", name);
        end else begin
            $display("test %s: %0d errors", name, errors - test_mark);
            tests_failed++;
        end
    endtask

    task automatic bus_write(input logic to_reg, input logic [AW-1:0] a, input logic [DW-1:0] d);
        @(posedge clk);
        addr   <= a;
        din    <= d;
        wr     <= 1'b1;
        reg_cs <= to_reg;
        buf_cs <= !to_reg;
    endtask

    task automatic bus_idle();
        @(posedge clk);
        wr     <= 1'b0;
        reg_cs <= 1'b0;
        buf_cs <= 1'b0;
    endtask

    // The buffer answers one cycle after the address, direct reads at once
    task automatic read_check(input string name, input logic [AW-1:0] a,
                              input logic [DW-1:0] expected);
        @(posedge clk);
        addr   <= a;
        wr     <= 1'b0;
        reg_cs <= 1'b0;
        buf_cs <= 1'b1;
        @(posedge clk);
        @(negedge clk);
        check($sformatf("%s @%h", name, a), expected, dout);
    endtask

    task automatic set_regs(input logic [7:0] ptr, input logic [2:0] bank);
        logic [31:0] r;
        r = next_rand();
        bus_write(1'b1, sprite_dma_pkg::REG_OBJ_PTR, {r[15:8], ptr});
        bus_write(1'b1, sprite_dma_pkg::REG_COPY_MODE, {r[31:27], bank, r[23:16]});
        bus_idle();
        obj_ptr_q = ptr;
        bank_q    = bank;
    endtask

    task automatic set_direct(input logic [1:0] mode);
        bus_write(1'b1, sprite_dma_pkg::REG_DIRECT, {14'b0, mode});
        bus_idle();
    endtask

    task automatic wait_busy(input logic level, input int limit, input string name);
        int n;
        n = 0;
        @(negedge clk);
        while (busy !== level && n < limit) begin
            @(negedge clk);
            n++;
        end
        if (busy !== level) begin
            $display("%s: busy did not go to %0d within %0d cycles", name, level, limit);
            errors++;
        end
    endtask

    // Expected RAM contents after one full copy run
    task automatic model_copy();
        int idx;
        int ptr;
        int cols;
        bit stop;
        for (int i = 0; i < PAL_WORDS; i++) begin
            exp_pal[bank_q * PAL_WORDS + i] = buf_model[PAL_BASE + i];
        end
        for (int i = 0; i < OBJ_WORDS; i++) begin
            exp_obj[i] = '0;
        end
        idx  = 256 - obj_ptr_q;
        ptr  = 0;
        stop = 1'b0;
        while (ptr < OBJ_WORDS && !stop) begin
            cols = 1 << buf_model[ptr][12:11];
            idx  = idx - cols;
            if (idx < 0) begin
                stop = 1'b1;
            end else begin
                for (int w = 0; w < 4; w++) begin
                    exp_obj[idx * 4 + w] = buf_model[ptr + w];
                end
                ptr = ptr + cols * 4;
            end
        end
    endtask

    task automatic run_copy(input string name, input int busy_writes);
        logic [31:0] r;
        model_copy();
        touched_q.delete();
        bus_write(1'b1, sprite_dma_pkg::REG_START, 16'h0000);
        bus_idle();
        wait_busy(1'b1, 4, name);
        for (int i = 0; i < busy_writes; i++) begin
            r = next_rand();
            bus_write(1'b0, r[10:0], r[31:16]); // Must be dropped, buffer model stays
            touched_q.push_back(r[10:0]);
        end
        bus_idle();
        wait_busy(1'b0, WAIT_LIMIT, name);
    endtask

    initial begin
        logic [31:0]   r;
        logic [AW-1:0] a;
        logic [DW-1:0] d;
        clk          = 1'b0;
        ce           = 1'b0;
        reset        = 1'b1;
        din          = '0;
        addr         = '0;
        reg_cs       = 1'b0;
        buf_cs       = 1'b0;
        wr           = 1'b0;
        count        = '0;
        rng          = SEED;
        ce_rng       = SEED;
        errors       = 0;
        tests_failed = 0;
        for (int i = 0; i < PAL_TOTAL; i++) begin
            pal_mem[i] = 16'(i) ^ 16'h5ac3;
            exp_pal[i] = 16'(i) ^ 16'h5ac3;
            if (i < OBJ_WORDS) begin
                obj_mem[i] = 16'(i) ^ 16'h3c96;
                exp_obj[i] = 16'(i) ^ 16'h3c96;
            end
        end
        repeat (10) @(posedge clk);
        reset <= 1'b0;

        test_mark = errors;
        @(negedge clk);
        check("reset busy", 1'b0, busy);
        check("reset obj_we", 1'b0, obj_we);
        check("reset pal_we", 1'b0, pal_we);
        check("reset pal_cs", 1'b0, pal_cs);
        for (int i = 0; i < 16; i++) begin
            r = next_rand();
            @(posedge clk);
            count <= r[9:0];
            @(negedge clk);
            check("scan obj_addr", r[9:0], obj_addr);
        end
        finish_test("reset state");

        test_mark = errors;
        for (int i = 0; i < OBJ_WORDS; i++) begin
            r = next_rand();
            bus_write(1'b0, AW'(i), r[15:0]);
            buf_model[i] = r[15:0];
        end
        bus_idle();
        for (int i = 0; i < OBJ_WORDS; i++) begin
            read_check("buffer", AW'(i), buf_model[i]);
        end
        r = next_rand();
        set_regs(r[7:0], r[10:8]);
        run_copy("buffer", 24);
        foreach (touched_q[i]) begin
            read_check("buffer written while busy", touched_q[i], buf_model[touched_q[i]]);
        end
        finish_test("buffer round trip");

        test_mark = errors;
        for (int round = 0; round < 2; round++) begin
            for (int i = 0; i < PAL_WORDS; i++) begin
                r = next_rand();
                a = AW'(PAL_BASE + i);
                bus_write(1'b0, a, r[15:0]);
                buf_model[a] = r[15:0];
            end
            bus_idle();
            r = next_rand();
            set_regs(r[7:0], r[10:8]);
            run_copy("palette", 0);
            for (int i = 0; i < PAL_TOTAL; i++) begin
                check($sformatf("palette[%0d]", i), exp_pal[i], pal_mem[i]);
            end
        end
        finish_test("palette copy");

        test_mark = errors;
        for (int round = 0; round < 4; round++) begin
            for (int i = 0; i < PAL_BASE; i++) begin
                r = next_rand();
                d = r[15:0];
                if (round == 3) begin
                    d[12:11] = 2'b00; // Every entry one column wide
                end
                bus_write(1'b0, AW'(i), d);
                buf_model[i] = d;
            end
            bus_idle();
            r = next_rand();
            set_regs((round == 0) ? 8'h00 : ((round == 1) ? 8'hff : r[7:0]), r[10:8]);
            run_copy("object", 0);
            for (int i = 0; i < OBJ_WORDS; i++) begin
                check($sformatf("object[%0d]", i), exp_obj[i], obj_mem[i]);
            end
        end
        finish_test("object clear and list copy");

        test_mark = errors;
        r = next_rand();
        set_regs(r[7:0], r[10:8]);
        for (int mode = 1; mode < 3; mode++) begin
            set_direct(2'(mode));
            touched_q.delete();
            for (int i = 0; i < 32; i++) begin
                r = next_rand();
                bus_write(1'b0, r[10:0], r[31:16]);
                touched_q.push_back(r[10:0]);
                if (mode == 1) begin
                    exp_obj[r[10:0]] = r[31:16];
                end else begin
                    exp_pal[{bank_q, r[9:0]}] = r[31:16];
                end
            end
            bus_idle();
            foreach (touched_q[i]) begin
                a = touched_q[i];
                if (mode == 1) begin
                    read_check("object direct", a, exp_obj[a]);
                    check("object direct ram", exp_obj[a], obj_mem[a]);
                end else begin
                    read_check("palette direct", a, exp_pal[{bank_q, a[9:0]}]);
                    check("palette direct pal_cs", 1'b1, pal_cs);
                end
            end
            set_direct(2'b00);
            foreach (touched_q[i]) begin
                read_check("buffer after direct", touched_q[i], buf_model[touched_q[i]]);
            end
        end
        finish_test("direct access");

        $display("5 tests run, %0d failed, %0d errors", tests_failed, errors);
        if (errors == 0) begin
            $display("All tests passed");
        end else begin
            $display("Some tests failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- verilog.f
sprite_dma_pkg.sv
list_ram.sv
cpu_port.sv
copy_engine.sv
memory_router.sv
sprite_list_dma.sv
sprite_list_dma_tb.sv

//--- Bender.yml
package:
  name: sprite_list_dma

sources:
  - sprite_dma_pkg.sv
  - list_ram.sv
  - cpu_port.sv
  - copy_engine.sv
  - memory_router.sv
  - sprite_list_dma.sv
  - target: test
    files:
      - sprite_list_dma_tb.sv
